// ==== hw/dbg_pkg.sv ====
/*
 * Serial debug bridge shared definitions
 * Character and counter widths, command frame layout, the five
 * accepted command words and the transfer sequencer state type
 */

`default_nettype none

package dbg_pkg;

	// ************************************************************
	// Widths and frame layout
	// ************************************************************

	localparam int BYTE_W       = 8;   // Serial character and memory data word
	localparam int CMD_W        = 32;  // Four ASCII characters of the command word
	localparam int FRAME_BYTES  = 8;   // One command copy, code + address + size
	localparam int HDR_FF_COUNT = 2;   // Leading 0xFF bytes of the header
	localparam int HDR_00_COUNT = 6;   // 0x00 bytes that follow them

	// Transfer counter, the top bit set means the last byte has gone
	localparam int CNT_W        = 17;

	// ************************************************************
	// Command words as they arrive, first character in the MSB
	// ************************************************************

	localparam logic [CMD_W-1:0] CMD_READ_BYTES  = 32'h5265_6164;  // "Read"
	localparam logic [CMD_W-1:0] CMD_READ_BURST  = 32'h5265_6150;  // "ReaP"
	localparam logic [CMD_W-1:0] CMD_WRITE_BYTES = 32'h5772_6974;  // "Writ"
	localparam logic [CMD_W-1:0] CMD_WRITE_BURST = 32'h5772_6950;  // "WriP"
	localparam logic [CMD_W-1:0] CMD_SET_PORTS   = 32'h5365_7450;  // "SetP"

	// Transfer sequencer states
	typedef enum logic [2:0] {
		IDLE,       // Waiting for a verified command
		RD_BUS,     // Wishbone read in flight
		RD_SEND,    // Read data offered to the transmitter
		WR_WAIT,    // Waiting for the next data byte from the host
		WR_BUS,     // Wishbone write in flight
		WR_ECHO,    // Written byte offered back for echo
		PORT_SEND   // Sampled inputs and address width going out
	} seq_state_t;

endpackage

`default_nettype wire

// ==== hw/uart_rx.sv ====
/*
 * Serial receiver, 8N1
 * Samples each bit at its centre and pulses rx_valid for one clock
 * in the middle of a good stop bit
 */

`default_nettype none

module uart_rx #(
	parameter int CLK_HZ    = 50_000_000,
	parameter int BAUD_RATE = 921_600
) (
	input  logic                       clk,
	input  logic                       cmd_rst,
	input  logic                       rxd,
	output logic [dbg_pkg::BYTE_W-1:0] rx_byte,
	output logic                       rx_valid
);
	import dbg_pkg::*;

	localparam int BIT_CLKS = CLK_HZ / BAUD_RATE;  // Clocks per bit
	localparam int HALF     = BIT_CLKS / 2;
	localparam int DIV_W    = $clog2(BIT_CLKS);

	logic              rxd_meta, rxd_sync, rxd_prev;  // Two stage synchronizer plus edge history
	logic              busy;                          // A frame is being sampled
	logic [DIV_W-1:0]  div_cnt;
	logic [3:0]        bit_idx;                       // 0 is the start bit, 9 the stop bit
	logic [BYTE_W-1:0] shreg;
	logic              sample;

	assign sample = busy && (div_cnt == '0);  // Centre of the current bit

	// ************************************************************
	// Framing control
	// ************************************************************
	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			rxd_meta <= 1'b1;  // Line idles high
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
			busy     <= 1'b0;
			div_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
			rx_valid <= 1'b0;
			if (!busy) begin
				if (rxd_prev && !rxd_sync) begin  // Falling edge opens a frame
					busy    <= 1'b1;
					div_cnt <= DIV_W'(HALF - 1);  // First sample lands mid start bit
					bit_idx <= '0;
				end
			end else if (!sample) begin
				div_cnt <= div_cnt - 1'b1;
			end else begin
				div_cnt <= DIV_W'(BIT_CLKS - 1);
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0 && rxd_sync)
					busy <= 1'b0;  // Glitch, the start bit did not hold low
				if (bit_idx == 4'd9) begin
					busy     <= 1'b0;
					rx_valid <= rxd_sync;  // A low stop bit drops the frame silently
				end
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			shreg <= {rxd_sync, shreg[BYTE_W-1:1]};
		if (sample && bit_idx == 4'd9 && rxd_sync)
			rx_byte <= shreg;  // Held until the next good frame
	end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
/*
 * Serial transmitter, 8N1
 * Takes one byte when tx_start is high and tx_busy is low and sends
 * start bit, data LSB first and stop bit from a 10-bit shift register
 */

`default_nettype none

module uart_tx #(
	parameter int CLK_HZ    = 50_000_000,
	parameter int BAUD_RATE = 921_600
) (
	input  logic                       clk,
	input  logic                       cmd_rst,
	input  logic [dbg_pkg::BYTE_W-1:0] tx_byte,
	input  logic                       tx_start,
	output logic                       tx_busy,
	output logic                       txd
);
	import dbg_pkg::*;

	localparam int BIT_CLKS = CLK_HZ / BAUD_RATE;
	localparam int DIV_W    = $clog2(BIT_CLKS);

	logic [BYTE_W+1:0] shreg;    // Stop, data, start. Bit 0 is on the line
	logic [DIV_W-1:0]  div_cnt;
	logic [3:0]        bit_cnt;  // Bits still to follow the current one
	logic              active;   // A frame is on the line
	logic              bit_end;

	assign bit_end = (div_cnt == '0);
	assign txd     = shreg[0];

	// Busy drops in the final clock of the stop bit, so a byte taken then
	// starts its start bit right where the stop bit ends and frames can
	// follow each other with no idle gap
	assign tx_busy = active && !(bit_cnt == 4'd0 && bit_end);

	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			shreg   <= '1;  // Idle line is high
			div_cnt <= '0;
			bit_cnt <= '0;
			active  <= 1'b0;
		end else if (tx_start && !tx_busy) begin
			shreg   <= {1'b1, tx_byte, 1'b0};
			div_cnt <= DIV_W'(BIT_CLKS - 1);
			bit_cnt <= 4'd9;
			active  <= 1'b1;
		end else if (active) begin
			if (!bit_end) begin
				div_cnt <= div_cnt - 1'b1;
			end else begin
				shreg   <= {1'b1, shreg[BYTE_W+1:1]};  // Ones fill in behind the stop bit
				div_cnt <= DIV_W'(BIT_CLKS - 1);
				if (bit_cnt == 4'd0)
					active <= 1'b0;
				else
					bit_cnt <= bit_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/cmd_frame_decoder.sv ====
/*
 * Command frame decoder
 * Shifts received bytes through a 16-byte buffer, tracks the 0xFF/0x00
 * header as it leaves the buffer and accepts a command only when both
 * 8-byte copies match behind a correct header
 */

`default_nettype none

module cmd_frame_decoder (
	input  logic                       clk,
	input  logic                       cmd_rst,
	input  logic [dbg_pkg::BYTE_W-1:0] rx_byte,
	input  logic                       rx_valid,
	input  logic                       cmd_idle,
	output logic                       cmd_valid,
	output logic [dbg_pkg::CMD_W-1:0]  cmd_code,
	output logic [23:0]                cmd_addr,
	output logic [dbg_pkg::BYTE_W-1:0] cmd_size
);
	import dbg_pkg::*;

	localparam int FRAME_W = FRAME_BYTES * BYTE_W;  // One command copy
	localparam int BUF_W   = 2 * FRAME_W;           // Older copy on top

	logic [BUF_W-1:0]  rx_buf;
	logic [BYTE_W-1:0] out_byte;        // Byte about to fall off the top
	logic [3:0]        cnt_ff, cnt_00;  // Saturating header run counters
	logic              shift_en;
	logic              fresh;           // Buffer took a byte on the last clock
	logic              hdr_ok, copies_match;

	function automatic logic [3:0] sat_inc(input logic [3:0] v);
		return (v == 4'hF) ? v : v + 4'd1;
	endfunction

	assign shift_en = rx_valid && cmd_idle;  // Data bytes of a write never enter
	assign out_byte = rx_buf[BUF_W-1 -: BYTE_W];

	// ************************************************************
	// Acceptance check
	// ************************************************************

	// The counters only see bytes that have left the buffer, so a match
	// means the header sits directly in front of the 16 command bytes
	assign hdr_ok       = (cnt_ff == 4'(HDR_FF_COUNT)) && (cnt_00 == 4'(HDR_00_COUNT));
	assign copies_match = (rx_buf[BUF_W-1:FRAME_W] == rx_buf[FRAME_W-1:0]);
	assign cmd_valid    = fresh && hdr_ok && copies_match;

	// Fields come from the newer copy, bytes 7..4 code, 3..1 address, 0 size
	assign cmd_code = rx_buf[FRAME_W-1 -: CMD_W];
	assign cmd_addr = rx_buf[4*BYTE_W-1:BYTE_W];
	assign cmd_size = rx_buf[BYTE_W-1:0];

	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			rx_buf <= '0;
			cnt_ff <= '0;
			cnt_00 <= '0;
			fresh  <= 1'b0;
		end else begin
			fresh <= shift_en;
			if (cmd_valid) begin
				rx_buf <= '0;  // A frame is consumed once
				cnt_ff <= '0;
				cnt_00 <= '0;
			end else if (shift_en) begin
				rx_buf <= {rx_buf[BUF_W-BYTE_W-1:0], rx_byte};
				if (out_byte == 8'hFF) begin
					// An 0xFF after zeros opens a new header run
					cnt_ff <= (cnt_00 != 4'd0) ? 4'd1 : sat_inc(cnt_ff);
					cnt_00 <= '0;
				end else if (out_byte == 8'h00) begin
					cnt_00 <= sat_inc(cnt_00);  // Zeros leave the 0xFF run standing
				end else begin
					cnt_ff <= '0;
					cnt_00 <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/xfer_sequencer.sv ====
/*
 * Transfer sequencer
 * Runs accepted commands, Wishbone classic master for memory reads
 * and writes, write echo, and the utility output and input ports
 */

`default_nettype none

module xfer_sequencer #(
	parameter int ADDR_W = 20
) (
	input  logic                       clk,
	input  logic                       cmd_rst,
	input  logic                       cmd_valid,
	input  logic [dbg_pkg::CMD_W-1:0]  cmd_code,
	input  logic [23:0]                cmd_addr,
	input  logic [dbg_pkg::BYTE_W-1:0] cmd_size,
	output logic                       cmd_idle,
	input  logic [dbg_pkg::BYTE_W-1:0] rx_byte,
	input  logic                       rx_valid,
	output logic [dbg_pkg::BYTE_W-1:0] tx_byte,
	output logic                       tx_start,
	input  logic                       tx_busy,
	output logic                       wb_cyc,
	output logic                       wb_stb,
	output logic                       wb_we,
	output logic [ADDR_W-1:0]          wb_adr,
	output logic [dbg_pkg::BYTE_W-1:0] wb_dat_o,
	input  logic [dbg_pkg::BYTE_W-1:0] wb_dat_i,
	input  logic                       wb_ack,
	input  logic [dbg_pkg::BYTE_W-1:0] in0, in1, in2, in3,
	output logic [dbg_pkg::BYTE_W-1:0] out0, out1, out2, out3
);
	import dbg_pkg::*;

	seq_state_t        state;
	logic [ADDR_W-1:0] addr_cnt;
	logic [CNT_W-1:0]  byte_cnt, cnt_dec;
	logic [BYTE_W-1:0] data_reg;                        // Read data or byte to write and echo
	logic [BYTE_W-1:0] in_reg0, in_reg1, in_reg2, in_reg3;  // Inputs frozen at SetP
	logic [BYTE_W-1:0] port_byte;
	logic              tx_take;

	assign cnt_dec  = byte_cnt - 1'b1;  // Wraps into the top bit after the last byte
	assign tx_take  = tx_start && !tx_busy;
	assign cmd_idle = (state == IDLE);

	// The bus cycle lasts exactly as long as the bus states
	assign wb_cyc   = (state == RD_BUS) || (state == WR_BUS);
	assign wb_stb   = wb_cyc;
	assign wb_we    = (state == WR_BUS);
	assign wb_adr   = addr_cnt;
	assign wb_dat_o = data_reg;

	assign tx_start = (state == RD_SEND) || (state == WR_ECHO) || (state == PORT_SEND);
	assign tx_byte  = (state == PORT_SEND) ? port_byte : data_reg;

	// Port report order follows the count down, in0 first, address width last
	always_comb begin
		case (byte_cnt[2:0])
			3'd4:    port_byte = in_reg0;
			3'd3:    port_byte = in_reg1;
			3'd2:    port_byte = in_reg2;
			3'd1:    port_byte = in_reg3;
			default: port_byte = BYTE_W'(ADDR_W);
		endcase
	end

	// ************************************************************
	// Command FSM
	// ************************************************************
	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			state    <= IDLE;
			addr_cnt <= '0;
			byte_cnt <= '0;
			out0     <= '0;
			out1     <= '0;
			out2     <= '0;
			out3     <= '0;
		end else begin
			case (state)
				IDLE: if (cmd_valid) begin
					addr_cnt <= cmd_addr[ADDR_W-1:0];
					case (cmd_code)
						CMD_READ_BYTES: begin
							byte_cnt <= CNT_W'(cmd_size);  // size+1 bytes
							state    <= RD_BUS;
						end
						CMD_READ_BURST: begin
							byte_cnt <= {1'b0, cmd_size, {BYTE_W{1'b1}}};  // (size+1)*256
							state    <= RD_BUS;
						end
						CMD_WRITE_BYTES: begin
							byte_cnt <= CNT_W'(cmd_size);
							state    <= WR_WAIT;
						end
						CMD_WRITE_BURST: begin
							byte_cnt <= {1'b0, cmd_size, {BYTE_W{1'b1}}};
							state    <= WR_WAIT;
						end
						CMD_SET_PORTS: begin
							// Address and size bytes carry the four port values
							out0     <= cmd_addr[23:16];
							out1     <= cmd_addr[15:8];
							out2     <= cmd_addr[7:0];
							out3     <= cmd_size;
							byte_cnt <= CNT_W'(4);  // Four inputs plus the width byte
							state    <= PORT_SEND;
						end
						default: ;  // Unknown words are dropped
					endcase
				end
				RD_BUS:  if (wb_ack) state <= RD_SEND;
				WR_WAIT: if (rx_valid) state <= WR_BUS;  // No timeout, waits for the host
				WR_BUS:  if (wb_ack) state <= WR_ECHO;
				RD_SEND, WR_ECHO: if (tx_take) begin
					addr_cnt <= addr_cnt + 1'b1;
					byte_cnt <= cnt_dec;
					if (cnt_dec[CNT_W-1])
						state <= IDLE;
					else
						state <= (state == RD_SEND) ? RD_BUS : WR_WAIT;
				end
				PORT_SEND: if (tx_take) begin
					byte_cnt <= cnt_dec;
					if (cnt_dec[CNT_W-1]) state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Payload captures
	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_valid && cmd_code == CMD_SET_PORTS) begin
			in_reg0 <= in0;  // All four sampled on the same clock
			in_reg1 <= in1;
			in_reg2 <= in2;
			in_reg3 <= in3;
		end
		if (state == RD_BUS && wb_ack)
			data_reg <= wb_dat_i;
		if (state == WR_WAIT && rx_valid)
			data_reg <= rx_byte;
	end

endmodule

`default_nettype wire

// ==== hw/rs232_debugger.sv ====
/*
 * RS-232 debug bridge, top level
 * Chains receiver, command decoder, transfer sequencer and transmitter
 * and exposes the Wishbone master and the utility ports
 */

`default_nettype none

module rs232_debugger #(
	parameter int CLK_HZ    = 50_000_000,
	parameter int BAUD_RATE = 921_600,
	parameter int ADDR_W    = 20         // 1 to 24
) (
	input  logic                       clk,
	input  logic                       cmd_rst,
	input  logic                       rxd,
	output logic                       txd,
	output logic                       wb_cyc,
	output logic                       wb_stb,
	output logic                       wb_we,
	output logic [ADDR_W-1:0]          wb_adr,
	output logic [dbg_pkg::BYTE_W-1:0] wb_dat_o,
	input  logic [dbg_pkg::BYTE_W-1:0] wb_dat_i,
	input  logic                       wb_ack,
	input  logic [dbg_pkg::BYTE_W-1:0] in0, in1, in2, in3,
	output logic [dbg_pkg::BYTE_W-1:0] out0, out1, out2, out3
);
	import dbg_pkg::*;

	logic [BYTE_W-1:0] rx_byte, tx_byte;
	logic              rx_valid, tx_start, tx_busy;
	logic              cmd_valid, cmd_idle;
	logic [CMD_W-1:0]  cmd_code;
	logic [23:0]       cmd_addr;
	logic [BYTE_W-1:0] cmd_size;

	// ************************************************************
	// Receive side
	// ************************************************************
	uart_rx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) i_uart_rx (
		.clk(clk), .cmd_rst(cmd_rst), .rxd(rxd), .rx_byte(rx_byte), .rx_valid(rx_valid)
	);

	cmd_frame_decoder i_decoder (
		.clk(clk), .cmd_rst(cmd_rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
		.cmd_idle(cmd_idle), .cmd_valid(cmd_valid), .cmd_code(cmd_code),
		.cmd_addr(cmd_addr), .cmd_size(cmd_size)
	);

	// Sequencer owns the bus, the ports and the transmitter
	xfer_sequencer #(.ADDR_W(ADDR_W)) i_sequencer (
		.clk(clk), .cmd_rst(cmd_rst), .cmd_valid(cmd_valid), .cmd_code(cmd_code),
		.cmd_addr(cmd_addr), .cmd_size(cmd_size), .cmd_idle(cmd_idle),
		.rx_byte(rx_byte), .rx_valid(rx_valid),
		.tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.in0(in0), .in1(in1), .in2(in2), .in3(in3),
		.out0(out0), .out1(out1), .out2(out2), .out3(out3)
	);

	uart_tx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) i_uart_tx (
		.clk(clk), .cmd_rst(cmd_rst), .tx_byte(tx_byte), .tx_start(tx_start),
		.tx_busy(tx_busy), .txd(txd)
	);

endmodule

`default_nettype wire

// ==== dv/dbg_checker.sv ====
/*
 * Serial debug bridge checker
 * Decodes the txd line into bytes, mirrors the host data of every acked
 * Wishbone write in a shadow memory and compares each returned byte,
 * each write and the output ports with the reference model
 */

`default_nettype none

module dbg_checker #(
	parameter int ADDR_W   = 12,
	parameter int BIT_CLKS = 16
) (
	input  logic                       clk,
	input  logic                       cmd_rst,
	input  logic                       txd,
	input  logic                       wb_cyc, wb_stb, wb_we, wb_ack,
	input  logic [ADDR_W-1:0]          wb_adr,
	input  logic [dbg_pkg::BYTE_W-1:0] wb_dat_o,
	input  logic [dbg_pkg::BYTE_W-1:0] in0, in1, in2, in3,
	input  logic [dbg_pkg::BYTE_W-1:0] out0, out1, out2, out3,
	input  logic                       quiet   // Host is sending frames that must be ignored
);
	import dbg_pkg::*;

	logic [7:0]        shadow [0:(1<<ADDR_W)-1];  // Memory as the host should see it
	logic [7:0]        exp_q[$];                  // Reply bytes still due on txd
	logic [ADDR_W+7:0] wr_q[$];                   // Address and data of writes still due
	logic [ADDR_W+7:0] wr_front;
	logic [ADDR_W-1:0] wr_addr;                   // Target of the next posted data byte
	logic [31:0]       snap;                      // Inputs as they stood when SetP went out
	logic [31:0]       out_exp, out_hold;
	logic              out_due = 1'b0;
	logic              quiet_d = 1'b0, cyc_d = 1'b0;
	int                pending = 0, val_errs = 0, other_errs = 0;
	int                quiet_cyc = 0, quiet_low = 0;

	// Init rule of the memory model mixes the upper nibble into the low byte
	function automatic logic [7:0] init_byte(input int a);
		return a[7:0] ^ 8'h5A ^ {a[11:8], 4'h0};
	endfunction

	// Byte idx of the reply to a read or SetP command
	function automatic logic [7:0] ref_byte(input logic [31:0] code, input int addr,
		input int idx);
		if (code == CMD_SET_PORTS)
			return (idx < 4) ? snap[idx*8 +: 8] : 8'(ADDR_W);  // in0 goes first and the width last
		return shadow[(addr + idx) % (1 << ADDR_W)];
	endfunction

	task automatic post_command(input logic [31:0] code, input int addr, input int size);
		int len;
		int i;
		len = (code == CMD_READ_BURST || code == CMD_WRITE_BURST) ? (size + 1) * 256 : size + 1;
		wr_addr = ADDR_W'(addr);
		if (code == CMD_SET_PORTS) begin
			len     = 5;
			snap    = {in3, in2, in1, in0};
			out_exp = {addr[23:0], size[7:0]};  // Address and size bytes carry the port values
			out_due = 1'b1;
		end
		if (code == CMD_READ_BYTES || code == CMD_READ_BURST || code == CMD_SET_PORTS)
			for (i = 0; i < len; i++)
				exp_q.push_back(ref_byte(code, addr, i));
		pending = exp_q.size();
	endtask

	// One data byte of a write is echoed unchanged and written at the next address
	task automatic post_data(input logic [7:0] d);
		exp_q.push_back(d);
		wr_q.push_back({wr_addr, d});
		wr_addr = wr_addr + 1'b1;
		pending = exp_q.size();
	endtask

	initial begin : fill_shadow
		int a;
		for (a = 0; a < (1 << ADDR_W); a++)
			shadow[a] = init_byte(a);
	end

	// ************************************************************
	// txd decoder and reply comparison
	// ************************************************************
	initial begin : decode_txd
		logic [7:0] b, e;
		int i;
		wait (!cmd_rst);
		forever begin
			@(negedge txd);
			repeat (BIT_CLKS / 2) @(posedge clk);  // Middle of the start bit
			for (i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(posedge clk);
				b[i] = txd;
			end
			repeat (BIT_CLKS) @(posedge clk);
			if (txd !== 1'b1) begin
				other_errs++;
				$display("Stop bit on txd was low at time %0t", $time);
			end
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("Byte 0x%h appeared on txd while no reply was due", b);
			end else begin
				e = exp_q.pop_front();
				if (b !== e) begin
					val_errs++;
					$display("ERR txd got 0x%h expected 0x%h", b, e);
				end
				if (out_due && {out0, out1, out2, out3} !== out_exp) begin
					val_errs++;
					$display("ERR out0..out3 got 0x%h expected 0x%h",
						{out0, out1, out2, out3}, out_exp);
				end
				out_due = 1'b0;  // Outputs settle on the accept clock long before this
			end
			pending = exp_q.size();
		end
	end

	// ************************************************************
	// Wishbone write monitor and rejected frame watch
	// ************************************************************
	always @(posedge clk) begin
		if (!cmd_rst && wb_cyc && wb_stb && wb_we && wb_ack) begin
			if (wr_q.size() == 0) begin
				other_errs++;
				$display("Wishbone write to 0x%h happened with no write due", wb_adr);
			end else begin
				wr_front = wr_q.pop_front();
				// Shadow takes the host data at the address it was meant for
				shadow[wr_front[ADDR_W+7:8]] <= wr_front[7:0];
				if (wb_adr !== wr_front[ADDR_W+7:8]) begin
					val_errs++;
					$display("ERR wb_adr got 0x%h expected 0x%h",
						wb_adr, wr_front[ADDR_W+7:8]);
				end
				if (wb_dat_o !== wr_front[7:0]) begin
					val_errs++;
					$display("ERR wb_dat_o got 0x%h expected 0x%h",
						wb_dat_o, wr_front[7:0]);
				end
			end
		end
		cyc_d   <= wb_cyc;
		quiet_d <= quiet;
		if (quiet && wb_cyc && !cyc_d)
			quiet_cyc++;
		if (quiet && txd !== 1'b1)
			quiet_low++;
		if (quiet && !quiet_d)
			out_hold <= {out0, out1, out2, out3};  // Port state before the bad frames
		if (!quiet && quiet_d) begin
			if (quiet_cyc != 0) begin
				other_errs++;
				$display("A Wishbone cycle started while only bad frames were sent");
			end
			if (quiet_low != 0) begin
				other_errs++;
				$display("txd left idle while only bad frames were sent");
			end
			if ({out0, out1, out2, out3} !== out_hold) begin
				val_errs++;
				$display("ERR out0..out3 got 0x%h expected 0x%h",
					{out0, out1, out2, out3}, out_hold);
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_rs232_debugger.sv ====
/*
 * Serial debug bridge testbench
 * Sends framed commands on rxd, models a Wishbone byte memory with
 * random wait states and runs the command set end to end
 */

`default_nettype none

module tb_rs232_debugger;
	import dbg_pkg::*;

	localparam int ADDR_W   = 12;
	localparam int BIT_CLKS = 16;  // Clocks per serial bit
	localparam int GAP_BITS = 2;   // Idle bits after each host byte
	// Nine full frames, one short frame and 261 write data bytes go out
	localparam int RX_BYTES = 9 * 24 + 23 + 5 + 256;
	localparam int TX_BYTES = 5 + 5 + 5 + 8 + 256 + 256 + 256 + 5;
	localparam int TIMEOUT  = (RX_BYTES + TX_BYTES) * 10 * BIT_CLKS * 40 * 2;

	logic              clk = 1'b0, cmd_rst = 1'b1, rxd = 1'b1, quiet = 1'b0;
	logic              txd;
	logic              wb_cyc, wb_stb, wb_we, wb_ack = 1'b0;
	logic [ADDR_W-1:0] wb_adr;
	logic [7:0]        wb_dat_o, wb_dat_i = 8'h00;
	logic [7:0]        in0 = 8'h3C, in1 = 8'hC3, in2 = 8'h96, in3 = 8'h69;
	logic [7:0]        out0, out1, out2, out3;
	logic [7:0]        mem [0:(1<<ADDR_W)-1];
	logic              ack_armed = 1'b0;
	int                ack_wait = 0;
	int                seed = 39;  // Shared by wait states and write data

	always #20 clk = ~clk;

	rs232_debugger #(.CLK_HZ(BIT_CLKS * 100_000), .BAUD_RATE(100_000), .ADDR_W(ADDR_W)) i_dut (
		.clk(clk), .cmd_rst(cmd_rst), .rxd(rxd), .txd(txd),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.in0(in0), .in1(in1), .in2(in2), .in3(in3),
		.out0(out0), .out1(out1), .out2(out2), .out3(out3)
	);

	dbg_checker #(.ADDR_W(ADDR_W), .BIT_CLKS(BIT_CLKS)) i_chk (
		.clk(clk), .cmd_rst(cmd_rst), .txd(txd), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o),
		.in0(in0), .in1(in1), .in2(in2), .in3(in3),
		.out0(out0), .out1(out1), .out2(out2), .out3(out3), .quiet(quiet)
	);

	// ************************************************************
	// Wishbone memory model
	// ************************************************************
	initial begin : fill_mem
		int a;
		for (a = 0; a < (1 << ADDR_W); a++)
			mem[a] = a[7:0] ^ 8'h5A ^ {a[11:8], 4'h0};
	end

	always @(posedge clk) begin
		wb_ack <= 1'b0;  // Ack lasts a single clock
		if (cmd_rst) begin
			ack_armed <= 1'b0;
		end else if (wb_cyc && wb_stb && !wb_ack) begin
			if (!ack_armed) begin
				ack_armed <= 1'b1;
				ack_wait  <= $random(seed) & 7;  // Zero to seven extra wait states
			end else if (ack_wait != 0) begin
				ack_wait <= ack_wait - 1;
			end else begin
				ack_armed <= 1'b0;
				wb_ack    <= 1'b1;
				wb_dat_i  <= mem[wb_adr];
				if (wb_we)
					mem[wb_adr] <= wb_dat_o;
			end
		end
	end

	// One 8N1 character on rxd sent LSB first and followed by a short idle gap
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10 + GAP_BITS; i++) begin
			@(posedge clk);
			rxd <= (i < 10) ? frame[i] : 1'b1;
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
	endtask

	// Header then two copies where zeros sets the length of the 0x00 run
	task automatic send_frame(input logic [63:0] copy_a, input logic [63:0] copy_b,
		input int zeros);
		int i;
		send_byte(8'hFF);
		send_byte(8'hFF);
		for (i = 0; i < zeros; i++)
			send_byte(8'h00);
		for (i = 7; i >= 0; i--)
			send_byte(copy_a[i*8 +: 8]);  // Code goes first and the size byte last
		for (i = 7; i >= 0; i--)
			send_byte(copy_b[i*8 +: 8]);
	endtask

	// Announces the command to the checker, sends a valid frame plus data and waits for the reply
	task automatic run_command(input logic [31:0] code, input logic [23:0] addr,
		input logic [7:0] size, input int n_data);
		logic [7:0] d;
		int i;
		i_chk.post_command(code, addr, size);
		send_frame({code, addr, size}, {code, addr, size}, HDR_00_COUNT);
		for (i = 0; i < n_data; i++) begin
			d = $random(seed);
			i_chk.post_data(d);
			send_byte(d);
		end
		wait (i_chk.pending == 0);
	endtask

	initial begin
		repeat (8) @(posedge clk);
		cmd_rst <= 1'b0;
		repeat (4) @(posedge clk);
		run_command(CMD_SET_PORTS, 24'hAABBCC, 8'hDD, 0);
		run_command(CMD_WRITE_BYTES, 24'h000100, 8'd4, 5);
		run_command(CMD_READ_BYTES, 24'h000100, 8'd4, 0);    // Read back the written range
		run_command(CMD_READ_BYTES, 24'h000300, 8'd7, 0);    // Untouched range keeps the init pattern
		run_command(CMD_READ_BURST, 24'h000200, 8'd0, 0);
		run_command(CMD_WRITE_BURST, 24'h000400, 8'd0, 256);
		run_command(CMD_READ_BYTES, 24'h000400, 8'd255, 0);
		// Unequal copies of a read and then a SetP whose header has only five zeros
		@(posedge clk);
		quiet <= 1'b1;
		send_frame({CMD_READ_BYTES, 32'h11223344}, {CMD_READ_BYTES, 32'h11223345}, HDR_00_COUNT);
		send_frame({CMD_SET_PORTS, 32'h11223344}, {CMD_SET_PORTS, 32'h11223344}, HDR_00_COUNT - 1);
		repeat (20 * BIT_CLKS) @(posedge clk);
		quiet <= 1'b0;
		in0   <= 8'h01;
		in1   <= 8'h80;
		in2   <= 8'hE7;
		in3   <= 8'h5B;
		repeat (2) @(posedge clk);
		run_command(CMD_SET_PORTS, 24'h123456, 8'h78, 0);  // Decoder must still accept
		repeat (4) @(posedge clk);
		$display("Checks done with %0d value errors and %0d other errors",
			i_chk.val_errs, i_chk.other_errs);
		if (i_chk.val_errs + i_chk.other_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog sized from twice the serial traffic of all tests
	initial begin
		#(TIMEOUT);
		$display("Watchdog expired with %0d reply bytes still outstanding", i_chk.pending);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hw/dbg_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_frame_decoder.sv
hw/xfer_sequencer.sv
hw/rs232_debugger.sv
dv/dbg_checker.sv
dv/tb_rs232_debugger.sv

// ==== Bender.yml ====
package:
  name: rs232_debugger

dependencies: {}

sources:
  - hw/dbg_pkg.sv
  - hw/uart_rx.sv
  - hw/uart_tx.sv
  - hw/cmd_frame_decoder.sv
  - hw/xfer_sequencer.sv
  - hw/rs232_debugger.sv
  - target: simulation
    files:
      - dv/dbg_checker.sv
      - dv/tb_rs232_debugger.sv
